// File: common/perf_pkg.sv
// Sizes, CSR addresses, event selector codes and functional-unit codes
package perf_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned NUM_COUNTERS = 6;
  localparam int unsigned CNT_W        = 64;   // Counter and CSR data width
  localparam int unsigned CSR_ADDR_W   = 12;
  localparam int unsigned EVT_SEL_W    = 5;
  localparam int unsigned NUM_COMMIT   = 2;    // Commit ports
  localparam int unsigned FU_W         = 4;
  localparam int unsigned SAMPLE_DEPTH = 8;
  localparam int unsigned VADDR_W      = 39;   // Sampled PC width
  localparam int unsigned CNT_IDX_W    = $clog2(NUM_COUNTERS);
  localparam int unsigned SAMPLE_PTR_W = $clog2(SAMPLE_DEPTH);

  // --------------------------------------------------
  // CSR addresses
  // --------------------------------------------------
  localparam logic [CSR_ADDR_W-1:0] CSR_MHPMCOUNTER3  = 12'hB03;  // Counters 3..8
  localparam logic [CSR_ADDR_W-1:0] CSR_MHPMEVENT3    = 12'h323;  // Selectors 3..8
  localparam logic [CSR_ADDR_W-1:0] CSR_THRESHOLD_CYC = 12'h7C0;

  // Event selector values, anything above EVT_FETCH_EMPTY counts nothing
  localparam logic [EVT_SEL_W-1:0] EVT_NONE         = 5'd0;
  localparam logic [EVT_SEL_W-1:0] EVT_ICACHE_MISS  = 5'd1;
  localparam logic [EVT_SEL_W-1:0] EVT_DCACHE_MISS  = 5'd2;
  localparam logic [EVT_SEL_W-1:0] EVT_ITLB_MISS    = 5'd3;
  localparam logic [EVT_SEL_W-1:0] EVT_DTLB_MISS    = 5'd4;
  localparam logic [EVT_SEL_W-1:0] EVT_LOAD         = 5'd5;
  localparam logic [EVT_SEL_W-1:0] EVT_STORE        = 5'd6;
  localparam logic [EVT_SEL_W-1:0] EVT_EXCEPTION    = 5'd7;
  localparam logic [EVT_SEL_W-1:0] EVT_BRANCH       = 5'd8;
  localparam logic [EVT_SEL_W-1:0] EVT_MISPREDICT   = 5'd9;
  localparam logic [EVT_SEL_W-1:0] EVT_SB_FULL      = 5'd10;
  localparam logic [EVT_SEL_W-1:0] EVT_FETCH_EMPTY  = 5'd11;

  // Functional-unit codes on the commit ports
  localparam logic [FU_W-1:0] FU_LOAD      = 4'd1;
  localparam logic [FU_W-1:0] FU_STORE     = 4'd2;
  localparam logic [FU_W-1:0] FU_CTRL_FLOW = 4'd3;

endpackage

// File: common/perf_cfg_if.sv
// Interface between the CSR register block and the counter bank
interface perf_cfg_if import perf_pkg::*; ();

  logic [EVT_SEL_W-1:0] evt_sel [NUM_COUNTERS];   // Selector registers, into the event mux
  logic [CNT_W-1:0]     cnt_val [NUM_COUNTERS];   // Current counter values

  // Counter load from a CSR write
  logic                 cnt_we;
  logic [CNT_IDX_W-1:0] cnt_widx;
  logic [CNT_W-1:0]     cnt_wdata;

  // Counter clear on a selector write
  logic                 cnt_clr;
  logic [CNT_IDX_W-1:0] cnt_cidx;

  logic                 count_en;   // Low in debug mode or during a CSR write

  modport csr (
    output cnt_we, cnt_widx, cnt_wdata, cnt_clr, cnt_cidx, count_en,
    input  cnt_val
  );

  modport bank (
    input  cnt_we, cnt_widx, cnt_wdata, cnt_clr, cnt_cidx, count_en,
    output cnt_val
  );

endinterface

// File: perf/perf_event_mux.sv
// Event select multiplexer, one event bit per programmable counter
module perf_event_mux import perf_pkg::*; (
  input  logic [EVT_SEL_W-1:0]            evt_sel_i [NUM_COUNTERS],
  input  logic                            l1_icache_miss_i,
  input  logic                            l1_dcache_miss_i,
  input  logic                            itlb_miss_i,
  input  logic                            dtlb_miss_i,
  input  logic [NUM_COMMIT-1:0]           commit_valid_i,
  input  logic [NUM_COMMIT-1:0][FU_W-1:0] commit_fu_i,
  input  logic                            ex_valid_i,
  input  logic                            branch_mispredict_i,
  input  logic                            sb_full_i,
  input  logic                            if_empty_i,
  output logic [NUM_COUNTERS-1:0]         events_o
);

  logic load_commit;
  logic store_commit;
  logic branch_commit;

  // --------------------------------------------------
  // Commit port reduction, shared by all counters
  // --------------------------------------------------
  always_comb begin
    load_commit   = 1'b0;
    store_commit  = 1'b0;
    branch_commit = 1'b0;
    for (int p = 0; p < NUM_COMMIT; p++) begin
      load_commit   |= commit_valid_i[p] && (commit_fu_i[p] == FU_LOAD);
      store_commit  |= commit_valid_i[p] && (commit_fu_i[p] == FU_STORE);
      branch_commit |= commit_valid_i[p] && (commit_fu_i[p] == FU_CTRL_FLOW);
    end
  end

  // Per-counter selection
  always_comb begin
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      case (evt_sel_i[k])
        EVT_NONE:        events_o[k] = 1'b0;
        EVT_ICACHE_MISS: events_o[k] = l1_icache_miss_i;
        EVT_DCACHE_MISS: events_o[k] = l1_dcache_miss_i;
        EVT_ITLB_MISS:   events_o[k] = itlb_miss_i;
        EVT_DTLB_MISS:   events_o[k] = dtlb_miss_i;
        EVT_LOAD:        events_o[k] = load_commit;
        EVT_STORE:       events_o[k] = store_commit;
        EVT_EXCEPTION:   events_o[k] = ex_valid_i;
        EVT_BRANCH:      events_o[k] = branch_commit;
        EVT_MISPREDICT:  events_o[k] = branch_mispredict_i;
        EVT_SB_FULL:     events_o[k] = sb_full_i;
        EVT_FETCH_EMPTY: events_o[k] = if_empty_i;
        default:         events_o[k] = 1'b0;   // Unassigned codes
      endcase
    end
  end

endmodule

// File: perf/perf_counter_bank.sv
// Bank of six 64-bit programmable counters with load, clear and increment
module perf_counter_bank import perf_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NUM_COUNTERS-1:0] events_i,
  input  logic [31:0]             mcountinhibit_i,
  perf_cfg_if.bank                cfg
);

  logic [CNT_W-1:0] cnt_q [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] inc;

  // Counter k maps to mhpmcounter k+3 in the inhibit mask
  always_comb begin
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      inc[k] = cfg.count_en && !mcountinhibit_i[k+3] && events_i[k];
    end
  end

  // --------------------------------------------------
  // Counter registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '{default: '0};
    end else begin
      for (int k = 0; k < NUM_COUNTERS; k++) begin
        if (cfg.cnt_we && (cfg.cnt_widx == CNT_IDX_W'(k))) begin
          cnt_q[k] <= cfg.cnt_wdata;            // CSR write wins
        end else if (cfg.cnt_clr && (cfg.cnt_cidx == CNT_IDX_W'(k))) begin
          cnt_q[k] <= '0;                       // New event selected
        end else if (inc[k]) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  assign cfg.cnt_val = cnt_q;

endmodule

// File: rtl/perf_csr_regs.sv
// CSR address decode, event selector and threshold registers, read data mux
module perf_csr_regs import perf_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  debug_mode_i,
  input  logic [CSR_ADDR_W-1:0] addr_i,
  input  logic                  we_i,
  input  logic [CNT_W-1:0]      data_i,
  output logic [CNT_W-1:0]      data_o,
  output logic [EVT_SEL_W-1:0]  evt_sel_o [NUM_COUNTERS],
  output logic [CNT_W-1:0]      threshold_cyc_o,
  perf_cfg_if.csr               cfg
);

  logic [EVT_SEL_W-1:0]  evt_sel_q [NUM_COUNTERS];
  logic [CNT_W-1:0]      threshold_q;

  logic [CSR_ADDR_W-1:0] cnt_off;
  logic [CSR_ADDR_W-1:0] evt_off;
  logic                  cnt_hit;
  logic                  evt_hit;
  logic                  thr_hit;
  logic [CNT_IDX_W-1:0]  cnt_idx;
  logic [CNT_IDX_W-1:0]  evt_idx;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // Below the base the offset wraps to a large value and misses
  assign cnt_off = addr_i - CSR_MHPMCOUNTER3;
  assign evt_off = addr_i - CSR_MHPMEVENT3;
  assign cnt_hit = (cnt_off < CSR_ADDR_W'(NUM_COUNTERS));
  assign evt_hit = (evt_off < CSR_ADDR_W'(NUM_COUNTERS));
  assign thr_hit = (addr_i == CSR_THRESHOLD_CYC);
  assign cnt_idx = cnt_off[CNT_IDX_W-1:0];
  assign evt_idx = evt_off[CNT_IDX_W-1:0];

  // Strobes to the counter bank
  assign cfg.cnt_we    = we_i && cnt_hit;
  assign cfg.cnt_widx  = cnt_idx;
  assign cfg.cnt_wdata = data_i;
  assign cfg.cnt_clr   = we_i && evt_hit;   // Selector write restarts its counter
  assign cfg.cnt_cidx  = evt_idx;
  assign cfg.count_en  = !debug_mode_i && !we_i;

  // --------------------------------------------------
  // Selector and threshold registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_sel_q   <= '{default: '0};
      threshold_q <= '0;
    end else if (we_i) begin
      if (evt_hit) begin
        evt_sel_q[evt_idx] <= data_i[EVT_SEL_W-1:0];
      end
      if (thr_hit) begin
        threshold_q <= data_i;
      end
    end
  end

  assign evt_sel_o       = evt_sel_q;
  assign threshold_cyc_o = threshold_q;

  // Read data, same cycle as the address
  always_comb begin
    data_o = '0;   // Unknown address
    if (cnt_hit) begin
      data_o = cfg.cnt_val[cnt_idx];
    end else if (evt_hit) begin
      data_o = CNT_W'(evt_sel_q[evt_idx]);
    end else if (thr_hit) begin
      data_o = threshold_q;
    end
  end

endmodule

// File: sampling/perf_sample_buffer.sv
// Cycle-threshold sample trigger and eight-entry PC sample FIFO
module perf_sample_buffer import perf_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [CNT_W-1:0]   threshold_cyc_i,
  input  logic [CNT_W-1:0]   cycle_count_i,
  input  logic [VADDR_W-1:0] pc_i,
  input  logic               sample_pop_i,
  output logic               sample_valid_o,
  output logic [VADDR_W-1:0] sample_pc_o
);

  logic [VADDR_W-1:0]    mem_q [SAMPLE_DEPTH];
  logic [SAMPLE_PTR_W-1:0] wr_ptr_q;
  logic [SAMPLE_PTR_W-1:0] rd_ptr_q;
  logic [SAMPLE_PTR_W:0]   fill_q;   // One extra bit to tell full from empty
  logic [CNT_W-1:0]      offset_q;   // Cycle count of the last sample

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (fill_q == (SAMPLE_PTR_W+1)'(SAMPLE_DEPTH));
  assign empty = (fill_q == '0);

  // --------------------------------------------------
  // Trigger
  // --------------------------------------------------
  // A zero threshold turns sampling off
  assign push = !full && (threshold_cyc_i != '0) &&
                (cycle_count_i >= threshold_cyc_i + offset_q);
  assign pop  = sample_pop_i && !empty;   // Pop on empty is dropped

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (push) begin
      offset_q <= cycle_count_i;
    end
  end

  // --------------------------------------------------
  // FIFO
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;   // Depth is a power of two, wraps
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;   // Both or neither
      endcase
    end
  end

  // Oldest entry shown combinationally
  assign sample_valid_o = !empty;
  assign sample_pc_o    = mem_q[rd_ptr_q];

endmodule

// File: rtl/perf_counters_top.sv
// Top level of the performance counter unit, block instances and wiring
module perf_counters_top import perf_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            debug_mode_i,
  // CSR port
  input  logic [CSR_ADDR_W-1:0]           addr_i,
  input  logic                            we_i,
  input  logic [CNT_W-1:0]                data_i,
  output logic [CNT_W-1:0]                data_o,
  // Events
  input  logic                            l1_icache_miss_i,
  input  logic                            l1_dcache_miss_i,
  input  logic                            itlb_miss_i,
  input  logic                            dtlb_miss_i,
  input  logic [NUM_COMMIT-1:0]           commit_valid_i,
  input  logic [NUM_COMMIT-1:0][FU_W-1:0] commit_fu_i,
  input  logic                            ex_valid_i,
  input  logic                            branch_mispredict_i,
  input  logic                            sb_full_i,
  input  logic                            if_empty_i,
  input  logic [31:0]                     mcountinhibit_i,
  // Sampler
  input  logic [CNT_W-1:0]                cycle_count_i,
  input  logic [VADDR_W-1:0]              pc_i,
  input  logic                            sample_pop_i,
  output logic                            sample_valid_o,
  output logic [VADDR_W-1:0]              sample_pc_o
);

  perf_cfg_if cfg ();

  logic [NUM_COUNTERS-1:0] events;
  logic [CNT_W-1:0]        threshold_cyc;

  perf_csr_regs i_csr_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .debug_mode_i    (debug_mode_i),
    .addr_i          (addr_i),
    .we_i            (we_i),
    .data_i          (data_i),
    .data_o          (data_o),
    .evt_sel_o       (cfg.evt_sel),
    .threshold_cyc_o (threshold_cyc),
    .cfg             (cfg.csr)
  );

  perf_event_mux i_event_mux (
    .evt_sel_i           (cfg.evt_sel),
    .l1_icache_miss_i    (l1_icache_miss_i),
    .l1_dcache_miss_i    (l1_dcache_miss_i),
    .itlb_miss_i         (itlb_miss_i),
    .dtlb_miss_i         (dtlb_miss_i),
    .commit_valid_i      (commit_valid_i),
    .commit_fu_i         (commit_fu_i),
    .ex_valid_i          (ex_valid_i),
    .branch_mispredict_i (branch_mispredict_i),
    .sb_full_i           (sb_full_i),
    .if_empty_i          (if_empty_i),
    .events_o            (events)
  );

  perf_counter_bank i_counter_bank (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .events_i        (events),
    .mcountinhibit_i (mcountinhibit_i),
    .cfg             (cfg.bank)
  );

  perf_sample_buffer i_sample_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .threshold_cyc_i (threshold_cyc),
    .cycle_count_i   (cycle_count_i),
    .pc_i            (pc_i),
    .sample_pop_i    (sample_pop_i),
    .sample_valid_o  (sample_valid_o),
    .sample_pc_o     (sample_pc_o)
  );

endmodule

// File: bench/tb_perf_counters.sv
// Table-driven testbench for the performance counter unit with a cycle-level reference model
module tb_perf_counters import perf_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_IDLE  = 2'd2;
  localparam logic [1:0] OP_POP   = 2'd3;

  // Event vector fields from the MSB down are if_empty, sb_full, mispredict, ex,
  // fu1, fu0, commit valid, dtlb, itlb, dcache and icache
  localparam logic [17:0] EV_A = {4'b0110, 4'd2, 4'd1, 2'b11, 4'b1001};
  localparam logic [17:0] EV_B = {4'b0110, 4'd1, 4'd2, 2'b11, 4'b1001};   // Ports swapped
  localparam logic [17:0] EV_C = {4'b0000, 4'd1, 4'd2, 2'b10, 4'b0000};   // Port 0 not valid

  typedef struct packed {
    logic [1:0]  op;
    logic [11:0] addr;
    logic [63:0] data;
    logic [17:0] ev;
    logic [31:0] inh;
    logic        dbg;
    logic [15:0] rep;
    logic [3:0]  test;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  debug_mode_i;
  logic [CSR_ADDR_W-1:0] addr_i;
  logic                  we_i;
  logic [CNT_W-1:0]      data_i;
  logic [CNT_W-1:0]      data_o;
  logic [17:0]           ev_q;
  logic [31:0]           mcountinhibit_i;
  logic [CNT_W-1:0]      cycle_count_i;
  logic [VADDR_W-1:0]    pc_i;
  logic                  sample_pop_i;
  logic                  sample_valid_o;
  logic [VADDR_W-1:0]    sample_pc_o;

  // Reference model state
  logic [CNT_W-1:0]      cnt_m [NUM_COUNTERS];
  logic [EVT_SEL_W-1:0]  sel_m [NUM_COUNTERS];
  logic [CNT_W-1:0]      thr_m;
  logic [CNT_W-1:0]      off_m;
  logic [VADDR_W-1:0]    fifo_m [$];
  logic [CNT_W-1:0]      cyc;
  entry_t                tbl [$];
  int                    errors;
  int                    checks;
  int                    limit_cycles;

  perf_counters_top UUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .debug_mode_i (debug_mode_i),
    .addr_i (addr_i), .we_i (we_i), .data_i (data_i), .data_o (data_o),
    .l1_icache_miss_i (ev_q[0]), .l1_dcache_miss_i (ev_q[1]),
    .itlb_miss_i (ev_q[2]), .dtlb_miss_i (ev_q[3]),
    .commit_valid_i (ev_q[5:4]), .commit_fu_i (ev_q[13:6]),
    .ex_valid_i (ev_q[14]), .branch_mispredict_i (ev_q[15]),
    .sb_full_i (ev_q[16]), .if_empty_i (ev_q[17]),
    .mcountinhibit_i (mcountinhibit_i), .cycle_count_i (cycle_count_i),
    .pc_i (pc_i), .sample_pop_i (sample_pop_i),
    .sample_valid_o (sample_valid_o), .sample_pc_o (sample_pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Reference model helpers
  // --------------------------------------------------
  function automatic logic event_bit(input logic [EVT_SEL_W-1:0] sel, input logic [17:0] e);
    logic ld;
    logic st;
    logic br;
    ld = (e[4] && e[9:6] == 4'd1) || (e[5] && e[13:10] == 4'd1);
    st = (e[4] && e[9:6] == 4'd2) || (e[5] && e[13:10] == 4'd2);
    br = (e[4] && e[9:6] == 4'd3) || (e[5] && e[13:10] == 4'd3);
    case (sel)
      5'd1:    return e[0];
      5'd2:    return e[1];
      5'd3:    return e[2];
      5'd4:    return e[3];
      5'd5:    return ld;
      5'd6:    return st;
      5'd7:    return e[14];
      5'd8:    return br;
      5'd9:    return e[15];
      5'd10:   return e[16];
      5'd11:   return e[17];
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [CNT_W-1:0] model_read(input logic [CSR_ADDR_W-1:0] a);
    if (a >= 12'hB03 && a <= 12'hB08) return cnt_m[3'(a - 12'hB03)];
    if (a >= 12'h323 && a <= 12'h328) return CNT_W'(sel_m[3'(a - 12'h323)]);
    if (a == 12'h7C0) return thr_m;
    return '0;   // Unmapped
  endfunction

  task automatic add_entry(input logic [1:0] op, input logic [11:0] addr,
                           input logic [63:0] data, input logic [17:0] ev,
                           input logic [31:0] inh, input logic dbg, input int rep,
                           input int test);
    tbl.push_back(entry_t'{op, addr, data, ev, inh, dbg, 16'(rep), 4'(test)});
  endtask

  task automatic add_write(input logic [11:0] a, input logic [63:0] d, input int t);
    add_entry(OP_WRITE, a, d, '0, '0, 1'b0, 1, t);
  endtask

  task automatic add_read(input logic [11:0] a, input int t);
    add_entry(OP_READ, a, '0, '0, '0, 1'b0, 1, t);
  endtask

  task automatic add_counter_reads(input int t);
    for (int k = 0; k < NUM_COUNTERS; k++) add_read(12'hB03 + 12'(k), t);
  endtask

  // Drive one clock cycle on the falling edge, check it and advance the model
  task automatic apply_cycle(input entry_t e);
    logic [VADDR_W-1:0] pc;
    logic               push;
    logic [CNT_W-1:0]   expected;
    @(negedge clk_i);
    pc = VADDR_W'({$urandom(), $urandom()});
    cyc = cyc + 1;
    addr_i = e.addr;
    we_i = (e.op == OP_WRITE);
    data_i = e.data;
    ev_q = e.ev;
    mcountinhibit_i = e.inh;
    debug_mode_i = e.dbg;
    sample_pop_i = (e.op == OP_POP);
    cycle_count_i = cyc;
    pc_i = pc;
    #1;
    checks++;
    assert (sample_valid_o == (fifo_m.size() != 0)) else begin
      $display("FAIL t=%0t sample_valid_o expected %0b got %0b", $time,
               fifo_m.size() != 0, sample_valid_o);
      errors++;
    end
    if (e.op == OP_READ) begin
      expected = model_read(e.addr);
      checks++;
      assert (data_o == expected) else begin
        $display("FAIL t=%0t data_o at %h expected %h got %h", $time, e.addr, expected, data_o);
        errors++;
      end
    end
    if (e.op == OP_POP && fifo_m.size() != 0) begin
      checks++;
      assert (sample_pc_o == fifo_m[0]) else begin
        $display("FAIL t=%0t sample_pc_o expected %h got %h", $time, fifo_m[0], sample_pc_o);
        errors++;
      end
    end
    // Trigger uses the state before the edge
    push = (fifo_m.size() < SAMPLE_DEPTH) && (thr_m != 0) && (cyc >= thr_m + off_m);
    if (e.op == OP_POP && fifo_m.size() != 0) void'(fifo_m.pop_front());
    if (push) begin
      fifo_m.push_back(pc);
      off_m = cyc;
    end
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      if (we_i && e.addr == 12'hB03 + 12'(k)) begin
        cnt_m[k] = e.data;
      end else if (we_i && e.addr == 12'h323 + 12'(k)) begin
        cnt_m[k] = '0;
        sel_m[k] = e.data[4:0];
      end else if (!e.dbg && !we_i && !e.inh[k+3] && event_bit(sel_m[k], e.ev)) begin
        cnt_m[k] = cnt_m[k] + 1;
      end
    end
    if (we_i && e.addr == 12'h7C0) thr_m = e.data;
  endtask

  task automatic report_test(input int test, input int errs);
    if (errs == 0) $display("Test %0d finished with no errors", test);
    else $display("Test %0d finished with %0d errors", test, errs);
  endtask

  // --------------------------------------------------
  // Stimulus table and run
  // --------------------------------------------------
  initial begin : main
    logic [EVT_SEL_W-1:0] sel_codes [NUM_COUNTERS];
    int cur_test;
    int test_start;
    int total_cycles;
    void'($urandom(32'hfebe));
    rst_ni = 1'b0;
    {debug_mode_i, addr_i, we_i, data_i, ev_q, mcountinhibit_i} = '0;
    {cycle_count_i, pc_i, sample_pop_i} = '0;
    {thr_m, off_m, cyc, errors, checks, limit_cycles} = '0;
    total_cycles = 0;
    cnt_m = '{default: '0};
    sel_m = '{default: '0};
    sel_codes = '{5'd5, 5'd6, 5'd1, 5'd4, 5'd9, 5'd10};
    add_counter_reads(1);   // Reset state
    for (int k = 0; k < NUM_COUNTERS; k++) add_read(12'h323 + 12'(k), 1);
    add_read(12'h7C0, 1);
    add_write(12'h323, 64'hFFFF_FFE5, 2);   // Register access
    add_read(12'h323, 2);
    add_write(12'hB04, 64'h1234_5678_9ABC_DEF0, 2);
    add_read(12'hB04, 2);
    add_write(12'hB05, 64'd77, 2);
    add_write(12'h325, 64'd3, 2);
    add_read(12'hB05, 2);
    add_read(12'h000, 2);
    add_read(12'hB09, 2);
    for (int k = 0; k < NUM_COUNTERS; k++) add_write(12'h323 + 12'(k), sel_codes[k], 3);
    add_write(12'hB03, 64'd100, 3);
    add_write(12'hB06, 64'd7, 3);
    add_entry(OP_IDLE, '0, '0, EV_A, '0, 1'b0, 10, 3);
    add_entry(OP_IDLE, '0, '0, EV_B, '0, 1'b0, 6, 3);
    add_entry(OP_IDLE, '0, '0, EV_C, '0, 1'b0, 4, 3);
    add_counter_reads(3);
    add_entry(OP_IDLE, '0, '0, EV_A, '0, 1'b1, 5, 4);   // Debug mode
    add_counter_reads(4);
    add_entry(OP_IDLE, '0, '0, EV_A, 32'h10, 1'b0, 5, 4);   // Counter 1 inhibited
    add_counter_reads(4);
    add_entry(OP_WRITE, 12'h7FF, '0, EV_A, '0, 1'b0, 3, 4);
    add_counter_reads(4);
    add_write(12'h7C0, 64'd5, 5);   // Sampling
    add_entry(OP_IDLE, '0, '0, '0, '0, 1'b0, 22, 5);
    add_entry(OP_POP, '0, '0, '0, '0, 1'b0, 6, 5);
    add_entry(OP_IDLE, '0, '0, '0, '0, 1'b0, 60, 6);   // Fill up
    add_read(12'h7C0, 6);
    add_entry(OP_POP, '0, '0, '0, '0, 1'b0, 1, 6);
    add_entry(OP_IDLE, '0, '0, '0, '0, 1'b0, 8, 6);
    add_entry(OP_POP, '0, '0, '0, '0, 1'b0, 10, 6);
    foreach (tbl[i]) total_cycles += tbl[i].rep;
    limit_cycles = total_cycles + 4 + 50;   // Reset cycles and margin
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    cur_test = tbl[0].test;
    test_start = 0;
    foreach (tbl[i]) begin
      if (tbl[i].test != cur_test) begin
        report_test(cur_test, errors - test_start);
        cur_test = tbl[i].test;
        test_start = errors;
      end
      repeat (tbl[i].rep) apply_cycle(tbl[i]);
    end
    report_test(cur_test, errors - test_start);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: the stimulus table did not finish within %0d cycles", limit_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: verilog.f
common/perf_pkg.sv
common/perf_cfg_if.sv
perf/perf_event_mux.sv
perf/perf_counter_bank.sv
rtl/perf_csr_regs.sv
sampling/perf_sample_buffer.sv
rtl/perf_counters_top.sv
bench/tb_perf_counters.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the performance counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_perf_counters -Mdir obj_dir -f verilog.f

./obj_dir/Vtb_perf_counters | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
